//--- source/icache_pkg.sv
`default_nettype none

package icache_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  localparam int addr_bits    = 16;
  localparam int block_bits   = 64;
  localparam int num_ways     = 4;
  localparam int num_sets     = 8;
  localparam int set_bits     = $clog2(num_sets);
  // block address minus set index
  localparam int tag_bits     = addr_bits - $clog2(block_bits / 8) - set_bits;
  localparam int queue_len    = 8;
  localparam int num_prefetch = 2;
  // zero is no tag, or busy
  localparam int mem_tag_bits = 4;

  typedef enum logic [1:0] {
    bus_none = 2'd0,
    bus_load = 2'd1
  } mem_command_t;

  // block address, tag above set
  typedef logic [tag_bits+set_bits-1:0] block_addr_t;

  //////////////////////////////////////////////////////////////////////
  // shared structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic                 valid;
    logic [addr_bits-1:0] addr;
  } fetch_t;

  typedef struct packed {
    logic                enable;
    logic [set_bits-1:0] set;
    logic [tag_bits-1:0] tag;
  } lookup_t;

  typedef struct packed {
    logic                  hit;
    logic [block_bits-1:0] data;
  } hit_t;

  typedef struct packed {
    logic                  valid;
    logic [set_bits-1:0]   set;
    logic [tag_bits-1:0]   tag;
    logic [block_bits-1:0] data;
  } fill_t;

  typedef struct packed {
    logic        valid;
    block_addr_t block;
  } mem_req_t;

  typedef struct packed {
    logic                    valid;
    block_addr_t             block;
    logic                    sent;
    logic [mem_tag_bits-1:0] mem_tag;
  } queue_entry_t;

endpackage

`default_nettype wire

//--- source/icache_store.sv
`timescale 1ns/10ps
`default_nettype none

module icache_store (
  input  wire logic                      clock,
  input  wire logic                      reset,
  input  wire icache_pkg::lookup_t [2:0] lookup,
  input  wire icache_pkg::fill_t         fill,
  output icache_pkg::hit_t [2:0]         hit
);

  // per set state
  logic [icache_pkg::num_ways-1:0] way_valid [icache_pkg::num_sets];
  logic [$clog2(icache_pkg::num_ways)-1:0] victim [icache_pkg::num_sets];

  // arrays, no reset
  logic [icache_pkg::tag_bits-1:0] way_tag
    [icache_pkg::num_sets][icache_pkg::num_ways];
  logic [icache_pkg::block_bits-1:0] way_data
    [icache_pkg::num_sets][icache_pkg::num_ways];

  logic [$clog2(icache_pkg::num_ways)-1:0] fill_way;
  logic fill_present;

  //////////////////////////////////////////////////////////////////////
  // lookups
  //////////////////////////////////////////////////////////////////////

  // three ports, all ways of the set compared at once
  always_comb begin
    for (int p = 0; p < 3; p++) begin
      hit[p] = '0;
      for (int w = 0; w < icache_pkg::num_ways; w++) begin
        if (lookup[p].enable && way_valid[lookup[p].set][w] &&
            way_tag[lookup[p].set][w] == lookup[p].tag) begin
          hit[p].hit  = 1'b1;
          hit[p].data = way_data[lookup[p].set][w];
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // fill
  //////////////////////////////////////////////////////////////////////

  // block already present gets rewritten in place
  always_comb begin
    fill_present = 1'b0;
    fill_way     = victim[fill.set];
    for (int w = 0; w < icache_pkg::num_ways; w++) begin
      if (way_valid[fill.set][w] && way_tag[fill.set][w] == fill.tag) begin
        fill_present = 1'b1;
        fill_way     = w[$clog2(icache_pkg::num_ways)-1:0];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int s = 0; s < icache_pkg::num_sets; s++) begin
        way_valid[s] <= '0;
        victim[s]    <= '0;
      end
    end else if (fill.valid) begin
      way_valid[fill.set][fill_way] <= 1'b1;
      // round robin, only when a new way is taken
      if (!fill_present) begin
        victim[fill.set] <= victim[fill.set] + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill.valid) begin
      way_tag[fill.set][fill_way]  <= fill.tag;
      way_data[fill.set][fill_way] <= fill.data;
    end
  end

endmodule

`default_nettype wire

//--- source/prefetch_queue.sv
`timescale 1ns/10ps
`default_nettype none

module prefetch_queue (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire icache_pkg::fetch_t                  fetch,
  input  wire logic                                fetch_hit,
  input  wire icache_pkg::hit_t                    head_hit,
  input  wire icache_pkg::hit_t                    pending_hit,
  input  wire logic                                req_accepted,
  input  wire logic [icache_pkg::mem_tag_bits-1:0] accepted_tag,
  input  wire logic                                req_busy,
  output icache_pkg::lookup_t                      head_lookup,
  output icache_pkg::lookup_t                      pending_lookup,
  output icache_pkg::mem_req_t                     mem_req
);

  icache_pkg::queue_entry_t [icache_pkg::queue_len-1:0] entries;
  icache_pkg::queue_entry_t [icache_pkg::queue_len-1:0] entries_next;
  logic [$clog2(icache_pkg::queue_len):0] tail;
  logic [$clog2(icache_pkg::queue_len):0] tail_next;
  logic [$clog2(icache_pkg::queue_len):0] send_ptr;
  logic [$clog2(icache_pkg::queue_len):0] send_next;
  logic [$clog2(icache_pkg::queue_len)-1:0] send_idx;
  logic in_flight;
  logic in_flight_next;
  icache_pkg::fetch_t last_fetch;
  icache_pkg::block_addr_t fetch_block;
  icache_pkg::block_addr_t [icache_pkg::num_prefetch:0] cand;
  logic [icache_pkg::num_prefetch:0] found;
  logic try_enqueue;
  logic retire;

  assign send_idx = send_ptr[$clog2(icache_pkg::queue_len)-1:0];
  assign fetch_block =
    fetch.addr[icache_pkg::addr_bits-1 -: $bits(icache_pkg::block_addr_t)];

  // head and next unsent entry are checked against the store
  assign head_lookup = '{enable: entries[0].valid,
                         set:    entries[0].block[icache_pkg::set_bits-1:0],
                         tag:    entries[0].block[$bits(icache_pkg::block_addr_t)-1:
                                                  icache_pkg::set_bits]};
  assign pending_lookup = '{enable: send_ptr < tail,
                            set:    entries[send_idx].block[icache_pkg::set_bits-1:0],
                            tag:    entries[send_idx].block[$bits(icache_pkg::block_addr_t)-1:
                                                            icache_pkg::set_bits]};

  // one request at a time until the port answers
  assign mem_req = '{valid: pending_lookup.enable && !pending_hit.hit && !in_flight,
                     block: entries[send_idx].block};

  assign retire = head_lookup.enable && head_hit.hit;

  //////////////////////////////////////////////////////////////////////
  // duplicate check over all valid entries
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int k = 0; k <= icache_pkg::num_prefetch; k++) begin
      cand[k]  = fetch_block + icache_pkg::block_addr_t'(k);
      found[k] = 1'b0;
      for (int i = 0; i < icache_pkg::queue_len; i++) begin
        if (entries[i].valid && entries[i].block == cand[k]) begin
          found[k] = 1'b1;
        end
      end
    end
  end

  // new address, or a miss dropped earlier while full
  assign try_enqueue = fetch.valid && !fetch_hit && (fetch != last_fetch || !found[0]);

  always_comb begin
    entries_next   = entries;
    tail_next      = tail;
    send_next      = send_ptr;
    in_flight_next = in_flight;
    if (mem_req.valid) begin
      in_flight_next = 1'b1;
    end else if (req_accepted || req_busy) begin
      in_flight_next = 1'b0;
    end
    // shift out a head that is now cached
    if (retire) begin
      entries_next = {icache_pkg::queue_entry_t'('0), entries[icache_pkg::queue_len-1:1]};
      tail_next    = tail - 1'b1;
      if (send_ptr != '0) begin
        send_next = send_ptr - 1'b1;
      end
    end
    if (req_accepted) begin
      entries_next[send_next[$clog2(icache_pkg::queue_len)-1:0]].sent    = 1'b1;
      entries_next[send_next[$clog2(icache_pkg::queue_len)-1:0]].mem_tag = accepted_tag;
      send_next = send_next + 1'b1;
    end else if (pending_lookup.enable && pending_hit.hit && !in_flight &&
                 !(retire && send_ptr == '0)) begin
      // already cached, nothing to load
      entries_next[send_next[$clog2(icache_pkg::queue_len)-1:0]].sent    = 1'b1;
      entries_next[send_next[$clog2(icache_pkg::queue_len)-1:0]].mem_tag = '0;
      send_next = send_next + 1'b1;
    end
    for (int k = 0; k <= icache_pkg::num_prefetch; k++) begin
      if (try_enqueue && !found[k] && tail_next < icache_pkg::queue_len) begin
        entries_next[tail_next[$clog2(icache_pkg::queue_len)-1:0]] =
          '{valid: 1'b1, block: cand[k], sent: 1'b0, mem_tag: '0};
        tail_next = tail_next + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      entries    <= '0;
      tail       <= '0;
      send_ptr   <= '0;
      in_flight  <= 1'b0;
      last_fetch <= '0;
    end else begin
      entries    <= entries_next;
      tail       <= tail_next;
      send_ptr   <= send_next;
      in_flight  <= in_flight_next;
      last_fetch <= fetch;
    end
  end

endmodule

`default_nettype wire

//--- source/mem_port.sv
`timescale 1ns/10ps
`default_nettype none

module mem_port (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire icache_pkg::mem_req_t                mem_req,
  input  wire logic [icache_pkg::mem_tag_bits-1:0] mem_response,
  input  wire logic [icache_pkg::block_bits-1:0]   mem_data,
  input  wire logic [icache_pkg::mem_tag_bits-1:0] mem_data_tag,
  output icache_pkg::mem_command_t                 mem_command,
  output logic [icache_pkg::addr_bits-1:0]         mem_addr,
  output logic                                     req_accepted,
  output logic [icache_pkg::mem_tag_bits-1:0]      accepted_tag,
  output logic                                     req_busy,
  output icache_pkg::fill_t                        fill
);

  logic req_valid;
  icache_pkg::block_addr_t req_block;

  // block address of each outstanding load, by tag
  icache_pkg::block_addr_t load_block [2**icache_pkg::mem_tag_bits];

  logic fill_valid;
  icache_pkg::block_addr_t fill_block;
  logic [icache_pkg::block_bits-1:0] fill_data;

  //////////////////////////////////////////////////////////////////////
  // command side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      req_valid <= 1'b0;
    end else begin
      req_valid <= mem_req.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_req.valid) begin
      req_block <= mem_req.block;
    end
  end

  assign mem_command = req_valid ? icache_pkg::bus_load : icache_pkg::bus_none;
  assign mem_addr    = req_valid ?
    {req_block, {$clog2(icache_pkg::block_bits / 8){1'b0}}} : '0;

  // answer comes back in the same cycle
  assign req_accepted = req_valid && mem_response != '0;
  assign req_busy     = req_valid && mem_response == '0;
  assign accepted_tag = mem_response;

  always_ff @(posedge clock) begin
    if (req_accepted) begin
      load_block[mem_response] <= req_block;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // data side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock) begin
    if (reset) begin
      fill_valid <= 1'b0;
    end else begin
      fill_valid <= mem_data_tag != '0;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_data_tag != '0) begin
      fill_block <= load_block[mem_data_tag];
      fill_data  <= mem_data;
    end
  end

  assign fill = '{valid: fill_valid,
                  set:   fill_block[icache_pkg::set_bits-1:0],
                  tag:   fill_block[$bits(icache_pkg::block_addr_t)-1:icache_pkg::set_bits],
                  data:  fill_data};

endmodule

`default_nettype wire

//--- source/icache_top.sv
`timescale 1ns/10ps
`default_nettype none

module icache_top (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire icache_pkg::fetch_t                  fetch,
  input  wire logic [icache_pkg::mem_tag_bits-1:0] mem_response,
  input  wire logic [icache_pkg::block_bits-1:0]   mem_data,
  input  wire logic [icache_pkg::mem_tag_bits-1:0] mem_data_tag,
  output logic [icache_pkg::block_bits-1:0]        fetch_data,
  output logic                                     fetch_hit,
  output icache_pkg::mem_command_t                 mem_command,
  output logic [icache_pkg::addr_bits-1:0]         mem_addr
);

  icache_pkg::block_addr_t fetch_block;
  icache_pkg::lookup_t fetch_lookup;
  icache_pkg::lookup_t head_lookup;
  icache_pkg::lookup_t pending_lookup;
  icache_pkg::hit_t [2:0] hit;
  icache_pkg::mem_req_t mem_req;
  logic req_accepted;
  logic req_busy;
  logic [icache_pkg::mem_tag_bits-1:0] accepted_tag;
  icache_pkg::fill_t fill;

  // fetch port goes straight to lookup port 0
  assign fetch_block =
    fetch.addr[icache_pkg::addr_bits-1 -: $bits(icache_pkg::block_addr_t)];
  assign fetch_lookup = '{enable: fetch.valid,
                          set:    fetch_block[icache_pkg::set_bits-1:0],
                          tag:    fetch_block[$bits(icache_pkg::block_addr_t)-1:
                                              icache_pkg::set_bits]};
  assign fetch_hit  = hit[0].hit;
  assign fetch_data = hit[0].data;

  icache_store i_store (
    .clock  (clock),
    .reset  (reset),
    .lookup ({pending_lookup, head_lookup, fetch_lookup}),
    .fill   (fill),
    .hit    (hit)
  );

  prefetch_queue i_queue (
    .clock          (clock),
    .reset          (reset),
    .fetch          (fetch),
    .fetch_hit      (fetch_hit),
    .head_hit       (hit[1]),
    .pending_hit    (hit[2]),
    .req_accepted   (req_accepted),
    .accepted_tag   (accepted_tag),
    .req_busy       (req_busy),
    .head_lookup    (head_lookup),
    .pending_lookup (pending_lookup),
    .mem_req        (mem_req)
  );

  mem_port i_port (
    .clock        (clock),
    .reset        (reset),
    .mem_req      (mem_req),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .req_accepted (req_accepted),
    .accepted_tag (accepted_tag),
    .req_busy     (req_busy),
    .fill         (fill)
  );

endmodule

`default_nettype wire

//--- bench/mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module mem_model (
  input  wire logic                                clock,
  input  wire logic                                reset,
  input  wire icache_pkg::mem_command_t            mem_command,
  input  wire logic [icache_pkg::addr_bits-1:0]    mem_addr,
  output logic [icache_pkg::mem_tag_bits-1:0]      mem_response,
  output logic [icache_pkg::block_bits-1:0]        mem_data,
  output logic [icache_pkg::mem_tag_bits-1:0]      mem_data_tag
);

  localparam int num_tags = 2**icache_pkg::mem_tag_bits;

  logic [num_tags-1:0] pending;
  icache_pkg::block_addr_t pending_block [num_tags];
  logic [3:0] wait_count [num_tags];
  logic [icache_pkg::mem_tag_bits-1:0] next_tag;
  logic [icache_pkg::mem_tag_bits-1:0] ready_tag;
  logic busy_roll;
  logic accept;

  // block number twice in the low half, inverted copy above
  function automatic logic [icache_pkg::block_bits-1:0] make_block_data(
    input icache_pkg::block_addr_t block
  );
    logic [31:0] low_half;
    low_half = {3'b000, block, 3'b000, block};
    return {~low_half, low_half};
  endfunction

  // answer in the same cycle as the load
  assign accept = mem_command == icache_pkg::bus_load && !busy_roll && !pending[next_tag];
  assign mem_response = accept ? next_tag : '0;

  // lowest tag whose latency has run out
  always_comb begin
    ready_tag = '0;
    for (int t = num_tags - 1; t > 0; t--) begin
      if (pending[t] && wait_count[t] == '0) begin
        ready_tag = t[icache_pkg::mem_tag_bits-1:0];
      end
    end
  end

  initial begin
    mem_data     = '0;
    mem_data_tag = '0;
    busy_roll    = 1'b0;
  end

  always @(posedge clock) begin
    if (reset) begin
      pending      <= '0;
      next_tag     <= 4'd1;
      busy_roll    <= 1'b0;
      mem_data_tag <= '0;
    end else begin
      // busy one time in four
      busy_roll    <= $urandom_range(3, 0) == 0;
      mem_data_tag <= ready_tag;
      if (ready_tag != '0) begin
        pending[ready_tag] <= 1'b0;
        mem_data           <= make_block_data(pending_block[ready_tag]);
      end
      for (int t = 0; t < num_tags; t++) begin
        if (wait_count[t] != '0) begin
          wait_count[t] <= wait_count[t] - 1'b1;
        end
      end
      if (accept) begin
        pending[next_tag]       <= 1'b1;
        pending_block[next_tag] <=
          mem_addr[icache_pkg::addr_bits-1 -: $bits(icache_pkg::block_addr_t)];
        // data 3 to 12 cycles later
        wait_count[next_tag]    <= 4'($urandom_range(11, 2));
        next_tag                <= (next_tag == 4'd15) ? 4'd1 : next_tag + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- bench/icache_props.sv
`timescale 1ns/10ps
`default_nettype none

module icache_props (
  input wire logic                                clock,
  input wire logic                                reset,
  input wire icache_pkg::mem_command_t            mem_command,
  input wire logic [icache_pkg::addr_bits-1:0]    mem_addr,
  input wire logic [icache_pkg::mem_tag_bits-1:0] mem_response,
  input wire logic [icache_pkg::mem_tag_bits-1:0] mem_data_tag,
  input wire icache_pkg::fill_t                   fill
);

  localparam int num_tags = 2**icache_pkg::mem_tag_bits;

  logic [num_tags-1:0] outstanding;
  icache_pkg::block_addr_t outstanding_block [num_tags];
  icache_pkg::block_addr_t load_block;
  logic load_clash;
  logic started = 1'b0;
  int failures = 0;

  assign load_block = mem_addr[icache_pkg::addr_bits-1 -: $bits(icache_pkg::block_addr_t)];

  always_comb begin
    load_clash = 1'b0;
    for (int t = 1; t < num_tags; t++) begin
      if (outstanding[t] && outstanding_block[t] == load_block) begin
        load_clash = 1'b1;
      end
    end
  end

  always @(posedge clock) begin
    started <= 1'b1;
  end

  // loads in flight, by tag
  always @(posedge clock) begin
    if (reset) begin
      outstanding <= '0;
    end else begin
      if (mem_data_tag != '0) begin
        outstanding[mem_data_tag] <= 1'b0;
      end
      if (mem_command == icache_pkg::bus_load && mem_response != '0) begin
        outstanding[mem_response]       <= 1'b1;
        outstanding_block[mem_response] <= load_block;
      end
    end
  end

  fill_follows_data: assert property (@(posedge clock) disable iff (reset)
    fill.valid == ($past(mem_data_tag) != '0))
    else begin
      $error("fill strobe does not follow returned data by one cycle");
      failures++;
    end

  no_repeat_load: assert property (@(posedge clock) disable iff (reset)
    mem_command == icache_pkg::bus_load |-> !load_clash)
    else begin
      $error("load issued for a block that is already outstanding");
      failures++;
    end

  idle_in_reset: assert property (@(posedge clock)
    (reset && started) |-> mem_command == icache_pkg::bus_none)
    else begin
      $error("bus command active during reset");
      failures++;
    end

endmodule

`default_nettype wire

//--- bench/icache_tb.sv
`timescale 1ns/10ps
`default_nettype none

module icache_tb;

  localparam int clock_period = 100;
  localparam int reset_cycles = 10;
  localparam int quiet_cycles = 2;
  localparam int num_rows     = 15;

  typedef struct {
    string                            name;
    logic [icache_pkg::addr_bits-1:0] addr;
    logic                             hit_now;
    int                               timeout;
  } row_t;

  logic clock;
  logic reset;
  icache_pkg::fetch_t fetch;
  logic [icache_pkg::mem_tag_bits-1:0] mem_response;
  logic [icache_pkg::block_bits-1:0] mem_data;
  logic [icache_pkg::mem_tag_bits-1:0] mem_data_tag;
  logic [icache_pkg::block_bits-1:0] fetch_data;
  logic fetch_hit;
  icache_pkg::mem_command_t mem_command;
  logic [icache_pkg::addr_bits-1:0] mem_addr;

  row_t rows [num_rows];
  logic table_ready = 1'b0;
  int check_errors;
  int tests_run;
  int tests_failed;

  icache_top i_dut (
    .clock        (clock),
    .reset        (reset),
    .fetch        (fetch),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag),
    .fetch_data   (fetch_data),
    .fetch_hit    (fetch_hit),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr)
  );

  mem_model i_mem (
    .clock        (clock),
    .reset        (reset),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data     (mem_data),
    .mem_data_tag (mem_data_tag)
  );

  bind icache_top icache_props i_props (
    .clock        (clock),
    .reset        (reset),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_data_tag (mem_data_tag),
    .fill         (fill)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // expected data and test table
  //////////////////////////////////////////////////////////////////////

  function automatic logic [icache_pkg::block_bits-1:0] expected_block_data(
    input logic [12:0] block
  );
    logic [31:0] low_half;
    low_half = {3'b000, block, 3'b000, block};
    return {~low_half, low_half};
  endfunction

  // sets 0 to 2 and 7 first, then five blocks of set 4
  task automatic fill_table();
    rows[0]  = '{"first_miss",      16'h0084, 1'b0, 300};
    rows[1]  = '{"repeat_hit",      16'h0080, 1'b1, 20};
    rows[2]  = '{"prefetch_next",   16'h0088, 1'b1, 20};
    rows[3]  = '{"prefetch_second", 16'h0094, 1'b1, 20};
    rows[4]  = '{"miss_other",      16'h0fc0, 1'b0, 300};
    rows[5]  = '{"wrap_miss",       16'hfff8, 1'b0, 300};
    rows[6]  = '{"wrap_prefetch",   16'h0002, 1'b1, 20};
    rows[7]  = '{"set4_way0",       16'h0120, 1'b0, 300};
    rows[8]  = '{"set4_way1",       16'h0160, 1'b0, 300};
    rows[9]  = '{"set4_way2",       16'h01a0, 1'b0, 300};
    rows[10] = '{"set4_way3",       16'h01e0, 1'b0, 300};
    rows[11] = '{"set4_evict",      16'h0220, 1'b0, 300};
    rows[12] = '{"fifth_hits",      16'h0224, 1'b1, 20};
    rows[13] = '{"first_evicted",   16'h0120, 1'b0, 300};
    rows[14] = '{"first_refilled",  16'h0126, 1'b1, 20};
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (check_errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // test steps
  //////////////////////////////////////////////////////////////////////

  task automatic check_reset_window();
    int errors_before;
    errors_before = check_errors;
    fetch = '{valid: 1'b1, addr: rows[0].addr};
    for (int c = 0; c < reset_cycles + quiet_cycles; c++) begin
      @(negedge clock);
      assert (!fetch_hit) else begin
        $display("ERROR reset_window: fetch_hit expected 0 actual %0b", fetch_hit);
        check_errors++;
      end
      assert (mem_command == icache_pkg::bus_none) else begin
        $display("ERROR reset_window: mem_command expected %0d actual %0d",
                 icache_pkg::bus_none, mem_command);
        check_errors++;
      end
      if (c == reset_cycles - 1) begin
        reset = 1'b0;
        fetch = '0;
      end
    end
    report_test("reset_window", errors_before);
  endtask

  task automatic run_row(input int r);
    int errors_before;
    int cycles;
    logic [12:0] block;
    errors_before = check_errors;
    block = rows[r].addr[15:3];
    @(negedge clock);
    fetch = '{valid: 1'b1, addr: rows[r].addr};
    #(clock_period / 4);
    assert (fetch_hit == rows[r].hit_now) else begin
      $display("ERROR %s: first cycle fetch_hit expected %0b actual %0b",
               rows[r].name, rows[r].hit_now, fetch_hit);
      check_errors++;
    end
    cycles = 0;
    @(negedge clock);
    while (!fetch_hit && cycles < rows[r].timeout) begin
      @(negedge clock);
      cycles++;
    end
    assert (fetch_hit) else begin
      $display("%s: fetch never hit within %0d cycles", rows[r].name, rows[r].timeout);
      check_errors++;
    end
    if (fetch_hit) begin
      assert (fetch_data == expected_block_data(block)) else begin
        $display("ERROR %s: fetch_data expected %h actual %h",
                 rows[r].name, expected_block_data(block), fetch_data);
        check_errors++;
      end
    end
    // prefetches finish before the next row
    fetch = '0;
    while (i_dut.i_queue.tail != '0 && cycles < rows[r].timeout) begin
      @(negedge clock);
      cycles++;
    end
    assert (i_dut.i_queue.tail == '0) else begin
      $display("%s: prefetch queue did not empty in time", rows[r].name);
      check_errors++;
    end
    report_test(rows[r].name, errors_before);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    reset        = 1'b1;
    fetch        = '0;
    check_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'he6c0));
    fill_table();
    table_ready  = 1'b1;
    check_reset_window();
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    if (i_dut.i_props.failures != 0) begin
      $display("bus assertions failed %0d times", i_dut.i_props.failures);
      check_errors += i_dut.i_props.failures;
    end
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             tests_run, tests_failed, check_errors);
    if (tests_failed == 0 && check_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    int limit;
    wait (table_ready == 1'b1);
    limit = reset_cycles + quiet_cycles + 4;
    for (int r = 0; r < num_rows; r++) begin
      limit += rows[r].timeout + 2;
    end
    repeat (limit) @(posedge clock);
    $display("watchdog: run did not finish within %0d cycles", limit);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
source/icache_pkg.sv
source/icache_store.sv
source/prefetch_queue.sv
source/mem_port.sv
source/icache_top.sv
bench/mem_model.sv
bench/icache_props.sv
bench/icache_tb.sv

//--- Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR       ?= verilator
TOP             ?= icache_tb
FILE_LIST       ?= files.f
BUILD_DIR       ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal
PASS_MESSAGE    ?= TESTS PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

# the run fails unless the pass line shows up in the output
run: compile
	@output="$$($(SIM))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)
